//--- dv/rv_core_tb.sv
// Testbench for the multicycle RV32I core.
// Runs a table of short programs from address 0 against a memory model
// with random wait states, then checks one result word per program.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;

    localparam int N_ROWS = 16;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    logic        clock;
    logic        reset;
    logic        mem_rd_en;
    logic        mem_wr_en;
    logic [3:0]  mem_byte_en;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_ack;
    logic        ecall;
    logic        illegal_instruction;

    logic [31:0] mem [256];
    logic [31:0] rng;
    logic        busy;
    int          wait_left;

    // Program table
    string       names [N_ROWS];
    logic [31:0] prog [N_ROWS][8];
    logic [31:0] res_addr [N_ROWS];
    logic [31:0] expected [N_ROWS];
    logic        ends_illegal [N_ROWS];
    logic [31:0] code [8];
    int          n_rows;
    int          current;
    int          passed;
    int          failed;

    rv_core rv_core_i (
        .clock, .reset,
        .mem_rd_en, .mem_wr_en, .mem_byte_en, .mem_addr, .mem_wdata,
        .mem_rdata, .mem_ack,
        .ecall, .illegal_instruction
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] store_result(input logic [4:0] rs2);
        return s_type(12'h200, rs2, 5'd0, 3'b010); // sw rs2, 0x200(x0)
    endfunction

    task automatic add_row(input string name, input logic [31:0] exp_word,
                           input logic illegal_end);
        names[n_rows]        = name;
        res_addr[n_rows]     = 32'h0000_0200;
        expected[n_rows]     = exp_word;
        ends_illegal[n_rows] = illegal_end;
        for (int i = 0; i < 8; i++) begin
            prog[n_rows][i] = code[i];
            code[i] = 32'h0; // Unused slots trap as illegal
        end
        n_rows++;
    endtask

    // x1 = -8, x2 = 5, then two branches that each skip a marker add
    task automatic branch_row(input string name, input logic [2:0] f3,
                              input logic [31:0] exp_word);
        code[0] = i_type(12'hff8, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = i_type(12'h005, 5'd0, 3'b000, 5'd2, `RV_OP_IMM);
        code[2] = b_type(13'd8, 5'd2, 5'd1, f3);
        code[3] = i_type(12'h001, 5'd3, 3'b000, 5'd3, `RV_OP_IMM);
        code[4] = b_type(13'd8, (f3[2:1] == 2'b00) ? 5'd2 : 5'd1, 5'd2, f3);
        code[5] = i_type(12'h002, 5'd3, 3'b000, 5'd3, `RV_OP_IMM);
        code[6] = store_result(5'd3);
        code[7] = ECALL_WORD;
        add_row(name, exp_word, 1'b0);
    endtask

    task automatic illegal_row(input string name, input logic [31:0] bad_word);
        code[0] = i_type(12'h055, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = store_result(5'd1);
        code[2] = bad_word;
        code[3] = ECALL_WORD; // Reached only if the bad word decodes as legal
        add_row(name, 32'h0000_0055, 1'b1);
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++)
            code[i] = 32'h0;
        code[0] = i_type(12'hff8, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = i_type(12'h005, 5'd0, 3'b000, 5'd2, `RV_OP_IMM);
        code[2] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);  // add  -> -3
        code[3] = r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);  // sub  -> 13
        code[4] = r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd5);  // xor
        code[5] = store_result(5'd5);
        code[6] = ECALL_WORD;
        add_row("alu_arith", 32'hffff_fff0, 1'b0);
        code[0] = i_type(12'hff8, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = i_type(12'h005, 5'd0, 3'b000, 5'd2, `RV_OP_IMM);
        code[2] = r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3);  // slt  -> 1
        code[3] = r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd4);  // sltu -> 1
        code[4] = r_type(7'h20, 5'd3, 5'd1, 3'b101, 5'd5);  // sra  -> -4
        code[5] = r_type(7'h00, 5'd4, 5'd5, 3'b000, 5'd5);
        code[6] = store_result(5'd5);
        code[7] = ECALL_WORD;
        add_row("alu_compare", 32'hffff_fffd, 1'b0);
        code[0] = u_type(20'h12345, 5'd1, `RV_OP_LUI);
        code[1] = u_type(20'h00010, 5'd2, `RV_OP_AUIPC);   // at PC 4
        code[2] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        code[3] = store_result(5'd3);
        code[4] = ECALL_WORD;
        add_row("lui_auipc", 32'h1235_5004, 1'b0);
        branch_row("beq", 3'b000, 32'd1);
        branch_row("bne", 3'b001, 32'd2);
        branch_row("blt", 3'b100, 32'd2);
        branch_row("bge", 3'b101, 32'd1);
        branch_row("bltu", 3'b110, 32'd1);
        branch_row("bgeu", 3'b111, 32'd2);
        code[0] = i_type(12'hf81, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = s_type(12'h100, 5'd1, 5'd0, 3'b000);
        code[2] = i_type(12'h100, 5'd0, 3'b000, 5'd2, `RV_OP_LOAD);  // lb
        code[3] = i_type(12'h100, 5'd0, 3'b100, 5'd3, `RV_OP_LOAD);  // lbu
        code[4] = r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd4);
        code[5] = store_result(5'd4);
        code[6] = ECALL_WORD;
        add_row("load_byte", 32'hffff_ff00, 1'b0);
        code[0] = u_type(20'h00008, 5'd1, `RV_OP_LUI);
        code[1] = i_type(12'h001, 5'd1, 3'b000, 5'd1, `RV_OP_IMM);
        code[2] = s_type(12'h104, 5'd1, 5'd0, 3'b001);
        code[3] = i_type(12'h104, 5'd0, 3'b001, 5'd2, `RV_OP_LOAD);  // lh
        code[4] = s_type(12'h108, 5'd2, 5'd0, 3'b010);
        code[5] = i_type(12'h108, 5'd0, 3'b010, 5'd3, `RV_OP_LOAD);  // lw
        code[6] = store_result(5'd3);
        code[7] = ECALL_WORD;
        add_row("load_half_word", 32'hffff_8001, 1'b0);
        code[0] = j_type(21'd8, 5'd1);                               // link 4
        code[1] = i_type(12'h100, 5'd0, 3'b000, 5'd5, `RV_OP_IMM);
        code[2] = i_type(12'h00c, 5'd1, 3'b000, 5'd2, `RV_OP_JALR);  // to 16 with link 12
        code[3] = i_type(12'h200, 5'd0, 3'b000, 5'd5, `RV_OP_IMM);
        code[4] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        code[5] = r_type(7'h00, 5'd5, 5'd3, 3'b000, 5'd3);          // x5 stays 0
        code[6] = store_result(5'd3);
        code[7] = ECALL_WORD;
        add_row("jal_jalr", 32'd16, 1'b0);
        illegal_row("illegal_zero", 32'h0000_0000);
        illegal_row("illegal_opcode", 32'h0000_007f);
        illegal_row("illegal_funct7", r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
        code[0] = i_type(12'h066, 5'd0, 3'b000, 5'd1, `RV_OP_IMM);
        code[1] = 32'h0ff0_000f;
        code[2] = store_result(5'd1);
        code[3] = ECALL_WORD;
        add_row("fence_ecall", 32'h0000_0066, 1'b0);
    endtask

    task automatic serve_access();
        logic [7:0] idx;
        idx = mem_addr[9:2];
        if (mem_wr_en) begin
            for (int k = 0; k < 4; k++)
                if (mem_byte_en[k])
                    mem[idx][8*k +: 8] = mem_wdata[8*k +: 8];
        end
        mem_rdata = mem[idx];
    endtask

    // Memory model with 0 to 3 wait cycles per request
    initial begin
        busy = 1'b0;
        wait_left = 0;
        rng = 32'h6723_876b;
        forever begin
            @(posedge clock);
            #1;
            if (reset || mem_ack) begin
                mem_ack = 1'b0;
                busy = 1'b0;
            end else if (mem_rd_en || mem_wr_en) begin
                if (!busy) begin
                    busy = 1'b1;
                    rng = xorshift32(rng);
                    wait_left = int'(rng[1:0]);
                end
                if (wait_left == 0) begin
                    serve_access();
                    mem_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        #(N_ROWS * 8 * 12 * 10);
        $display("Watchdog expired in test %s, controller in state %s",
                 names[current], rv_core_i.control_unit_i.state.name());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic        got_illegal;
        logic [31:0] actual;
        logic        end_ok;
        logic        value_ok;
        reset = 1'b1;
        mem_ack = 1'b0;
        mem_rdata = 32'h0;
        n_rows = 0;
        current = 0;
        passed = 0;
        failed = 0;
        build_table();
        for (int t = 0; t < n_rows; t++) begin
            current = t;
            @(posedge clock);
            #1;
            reset = 1'b1;
            for (int i = 0; i < 256; i++)
                mem[i] = {8'ha5, i[7:0], ~i[7:0], 8'h5a};
            for (int i = 0; i < 8; i++)
                mem[i] = prog[t][i];
            repeat (3) @(posedge clock);
            #1;
            reset = 1'b0;
            do
                @(negedge clock);
            while (!ecall && !illegal_instruction);
            got_illegal = illegal_instruction;
            actual = mem[res_addr[t][9:2]];
            end_ok = (got_illegal == ends_illegal[t]);
            value_ok = (actual == expected[t]);
            assert (end_ok) else begin
                $display("Test %s ended on %s instead of %s", names[t],
                         got_illegal ? "illegal_instruction" : "ecall",
                         ends_illegal[t] ? "illegal_instruction" : "ecall");
            end
            assert (value_ok) else begin
                $display("** Error %s: expected %08h, actual %08h", names[t],
                         expected[t], actual);
            end
            if (end_ok && value_ok) begin
                passed++;
                $display("test %s ok", names[t]);
            end else begin
                failed++;
                $display("test %s failed", names[t]);
            end
        end
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module rv_core_tb -f rv_core.f \
    && ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    || { echo "Simulation failed"; exit 1; }

//--- rv_core.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/rv_core.sv
dv/rv_core_tb.sv

//--- verilog/alu.sv
// Combinational RV32I ALU.
// alu_op is {funct7[0], funct3}; the flags always come from the adder
// so the controller can resolve branches from a subtraction.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  logic [3:0]          alu_op,
    input  logic                sub,
    input  logic                arithmetic,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero,
    output logic                negative,
    output logic                carry_out,
    output logic                overflow
);

    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN:0]   sum_full;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] sra_result;
    logic                slt;
    logic                sltu;

    assign b_eff    = sub ? ~b : b;
    assign sum_full = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub};
    assign sum      = sum_full[`RV_XLEN-1:0];

    assign zero      = (sum == '0);
    assign negative  = sum[`RV_XLEN-1];
    assign carry_out = sum_full[`RV_XLEN]; // Set when a >= b on subtract
    assign overflow  = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1])
                     && (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);

    assign slt  = $signed(a) < $signed(b);
    assign sltu = a < b;

    assign sra_result = $signed(a) >>> b[4:0];

    always_comb begin
        case (alu_op)
            4'h1: result = a << b[4:0];
            4'h2: result = {{(`RV_XLEN-1){1'b0}}, slt};
            4'h3: result = {{(`RV_XLEN-1){1'b0}}, sltu};
            4'h4: result = a ^ b;
            4'h5: result = arithmetic ? sra_result : a >> b[4:0];
            4'h6: result = a | b;
            4'h7: result = a & b;
            default: result = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
// Multicycle control FSM for the RV32I core.
// Steps every instruction through FETCH, DECODE and one execute state,
// checks the encoding for legality and resolves branches from the ALU flags.
// Memory requests are held until mem_ack.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module control_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_ack,
    input  rv_pkg::instr_word_t instr,
    input  logic                zero,
    input  logic                negative,
    input  logic                carry_out,
    input  logic                overflow,
    output logic                mem_rd_en,
    output logic                mem_wr_en,
    output logic [3:0]          mem_byte_en,
    output logic                alua_src,
    output logic                alub_src,
    output logic [3:0]          alu_op,
    output logic                sub,
    output logic                arithmetic,
    output logic                alupc_src,
    output logic                pc_src,
    output logic                pc_en,
    output rv_pkg::wb_sel_t     wb_sel,
    output logic                wr_reg_en,
    output logic                ir_en,
    output logic                mem_addr_src,
    output logic                ecall,
    output logic                illegal_instruction
);

    rv_pkg::ctrl_state_t state;
    rv_pkg::ctrl_state_t next_state;
    rv_pkg::ctrl_state_t decoded;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       base_f7;
    logic       alt_f7;
    logic       branch_cond;
    logic       branch_taken;
    logic [3:0] access_en;

    assign opcode = instr.r_view.opcode;
    assign funct3 = instr.r_view.funct3;
    assign funct7 = instr.r_view.funct7;
    assign base_f7 = (funct7 == 7'h00);
    assign alt_f7  = (funct7 == 7'h20); // SUB / SRA / SRAI

    // eq, lt, ltu; funct3[0] inverts
    assign branch_cond  = funct3[1] ? ~carry_out
                        : (funct3[2] ? (negative ^ overflow) : zero);
    assign branch_taken = branch_cond ^ funct3[0];

    assign access_en = funct3[1] ? 4'hF : (funct3[0] ? 4'h3 : 4'h1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= rv_pkg::IDLE;
        else
            state <= next_state;
    end

    // Legality check and execute-state selection
    always_comb begin
        decoded = rv_pkg::ILLEGAL;
        case (opcode)
            `RV_OP_REG: begin
                if (base_f7 || (alt_f7 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    decoded = rv_pkg::REG_REG;
            end
            `RV_OP_IMM: begin
                if (funct3[1:0] != 2'b01 || base_f7 || (alt_f7 && funct3[2]))
                    decoded = rv_pkg::REG_IMM;
            end
            `RV_OP_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11)
                    decoded = rv_pkg::LOAD;
            end
            `RV_OP_STORE: begin
                if (!funct3[2] && funct3[1:0] != 2'b11)
                    decoded = rv_pkg::STORE;
            end
            `RV_OP_BRANCH: begin
                if (funct3[2:1] != 2'b01)
                    decoded = rv_pkg::BRANCH;
            end
            `RV_OP_LUI:   decoded = rv_pkg::LUI;
            `RV_OP_AUIPC: decoded = rv_pkg::AUIPC;
            `RV_OP_JAL:   decoded = rv_pkg::JAL;
            `RV_OP_JALR: begin
                if (funct3 == 3'b000)
                    decoded = rv_pkg::JALR;
            end
            `RV_OP_FENCE: decoded = rv_pkg::FENCE;
            `RV_OP_SYSTEM: begin
                // Only ECALL, every other field zero
                if ({funct7, instr.r_view.rs2, instr.r_view.rs1, funct3,
                     instr.r_view.rd} == 25'd0)
                    decoded = rv_pkg::ECALL;
            end
            default: decoded = rv_pkg::ILLEGAL;
        endcase
    end

    always_comb begin
        mem_rd_en           = 1'b0;
        mem_wr_en           = 1'b0;
        mem_byte_en         = 4'h0;
        alua_src            = 1'b0;
        alub_src            = 1'b0;
        alu_op              = 4'h0;
        sub                 = 1'b0;
        arithmetic          = 1'b0;
        alupc_src           = 1'b0;
        pc_src              = 1'b0;
        pc_en               = 1'b0;
        wb_sel              = rv_pkg::ALU;
        wr_reg_en           = 1'b0;
        ir_en               = 1'b0;
        mem_addr_src        = 1'b0;
        ecall               = 1'b0;
        illegal_instruction = 1'b0;
        next_state          = rv_pkg::FETCH;

        case (state)
            rv_pkg::IDLE: next_state = rv_pkg::FETCH;
            rv_pkg::FETCH: begin
                mem_rd_en   = 1'b1;
                mem_byte_en = 4'hF;
                if (mem_ack) begin
                    ir_en      = 1'b1;
                    next_state = rv_pkg::DECODE;
                end else begin
                    next_state = rv_pkg::FETCH;
                end
            end
            rv_pkg::DECODE: next_state = decoded;
            rv_pkg::REG_REG: begin
                alu_op     = {funct7[0], funct3};
                sub        = funct7[5];
                arithmetic = funct7[5];
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
            end
            rv_pkg::REG_IMM: begin
                alub_src   = 1'b1;
                alu_op     = {1'b0, funct3};
                arithmetic = funct7[5] & (funct3 == 3'b101); // SRAI only
                pc_en      = 1'b1;
                wr_reg_en  = 1'b1;
            end
            rv_pkg::LUI: begin
                alub_src  = 1'b1;
                pc_en     = 1'b1;
                wr_reg_en = 1'b1;
            end
            rv_pkg::AUIPC: begin
                alua_src  = 1'b1;
                alub_src  = 1'b1;
                pc_en     = 1'b1;
                wr_reg_en = 1'b1;
            end
            rv_pkg::JAL: begin
                pc_src    = 1'b1;
                pc_en     = 1'b1;
                wb_sel    = rv_pkg::PC_PLUS4;
                wr_reg_en = 1'b1;
            end
            rv_pkg::JALR: begin
                alub_src  = 1'b1;
                alupc_src = 1'b1; // Target from rs1 + imm
                pc_src    = 1'b1;
                pc_en     = 1'b1;
                wb_sel    = rv_pkg::PC_PLUS4;
                wr_reg_en = 1'b1;
            end
            rv_pkg::BRANCH: begin
                sub    = 1'b1;
                pc_src = branch_taken;
                pc_en  = 1'b1;
            end
            rv_pkg::LOAD: begin
                mem_rd_en    = 1'b1;
                mem_byte_en  = access_en;
                mem_addr_src = 1'b1;
                alub_src     = 1'b1;
                wb_sel       = rv_pkg::MEM;
                if (mem_ack) begin
                    pc_en     = 1'b1;
                    wr_reg_en = 1'b1;
                end else begin
                    next_state = rv_pkg::LOAD;
                end
            end
            rv_pkg::STORE: begin
                mem_wr_en    = 1'b1;
                mem_byte_en  = access_en;
                mem_addr_src = 1'b1;
                alub_src     = 1'b1;
                if (mem_ack)
                    pc_en = 1'b1;
                else
                    next_state = rv_pkg::STORE;
            end
            rv_pkg::ECALL: begin
                ecall = 1'b1;
                pc_en = 1'b1;
            end
            rv_pkg::FENCE: pc_en = 1'b1; // Nothing to order
            rv_pkg::ILLEGAL: begin
                illegal_instruction = 1'b1;
                pc_en               = 1'b1;
            end
            default: next_state = rv_pkg::IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
// Datapath of the multicycle core: PC, instruction register, immediate
// decode, ALU operand and writeback muxes, and the memory address and data.
// Every select comes from control_unit; the ALU flags go back to it.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module datapath (
    input  logic                clock,
    input  logic                reset,
    input  logic                alua_src,
    input  logic                alub_src,
    input  logic [3:0]          alu_op,
    input  logic                sub,
    input  logic                arithmetic,
    input  logic                alupc_src,
    input  logic                pc_src,
    input  logic                pc_en,
    input  rv_pkg::wb_sel_t     wb_sel,
    input  logic                wr_reg_en,
    input  logic                ir_en,
    input  logic                mem_addr_src,
    output rv_pkg::instr_word_t instr,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic                zero,
    output logic                negative,
    output logic                carry_out,
    output logic                overflow,
    input  logic [`RV_XLEN-1:0] mem_rdata
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] jump_target;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic [4:0]          rs1_addr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            pc <= `RV_RESET_PC;
        else if (pc_en)
            pc <= next_pc;
    end

    always_ff @(posedge clock) begin
        if (ir_en)
            instr <= mem_rdata;
    end

    // Immediate by format
    always_comb begin
        case (instr.r_view.opcode)
            `RV_OP_STORE:
                imm = {{(`RV_XLEN-12){instr.s_view.imm_hi[6]}},
                       instr.s_view.imm_hi, instr.s_view.imm_lo};
            `RV_OP_BRANCH:
                imm = {{(`RV_XLEN-12){instr.s_view.imm_hi[6]}},
                       instr.s_view.imm_lo[0], instr.s_view.imm_hi[5:0],
                       instr.s_view.imm_lo[4:1], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
                       instr.r_view.funct3, 12'h000};
            `RV_OP_JAL:
                imm = {{(`RV_XLEN-20){instr.r_view.funct7[6]}},
                       instr.r_view.rs1, instr.r_view.funct3, instr.r_view.rs2[0],
                       instr.r_view.funct7[5:0], instr.r_view.rs2[4:1], 1'b0};
            default: // I-type
                imm = {{(`RV_XLEN-12){instr.r_view.funct7[6]}},
                       instr.r_view.funct7, instr.r_view.rs2};
        endcase
    end

    // LUI reads x0 so the ALU passes the immediate
    assign rs1_addr = (instr.r_view.opcode == `RV_OP_LUI) ? 5'd0 : instr.r_view.rs1;

    register_file register_file_i (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (wr_reg_en),
        .rs1_addr (rs1_addr),
        .rs2_addr (instr.r_view.rs2),
        .rd_addr  (instr.r_view.rd),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = alua_src ? pc : rs1_data;
    assign alu_b = alub_src ? imm : rs2_data;

    alu alu_i (
        .a          (alu_a),
        .b          (alu_b),
        .alu_op     (alu_op),
        .sub        (sub),
        .arithmetic (arithmetic),
        .result     (alu_result),
        .zero       (zero),
        .negative   (negative),
        .carry_out  (carry_out),
        .overflow   (overflow)
    );

    assign pc_plus4    = pc + 32'd4;
    assign jump_target = alupc_src ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc + imm;
    assign next_pc     = pc_src ? jump_target : pc_plus4;

    // Lanes are not shifted, data sits in the low bytes
    always_comb begin
        case (instr.r_view.funct3)
            3'b000:  load_data = {{(`RV_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
            3'b001:  load_data = {{(`RV_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
            3'b100:  load_data = {{(`RV_XLEN-8){1'b0}}, mem_rdata[7:0]};
            3'b101:  load_data = {{(`RV_XLEN-16){1'b0}}, mem_rdata[15:0]};
            default: load_data = mem_rdata;
        endcase
    end

    always_comb begin
        case (wb_sel)
            rv_pkg::MEM:      wb_data = load_data;
            rv_pkg::PC_PLUS4: wb_data = pc_plus4; // Link value
            default:          wb_data = alu_result;
        endcase
    end

    assign mem_addr  = mem_addr_src ? alu_result : pc;
    assign mem_wdata = rs2_data;

endmodule

`default_nettype wire

//--- verilog/register_file.sv
// Architectural register file, two asynchronous read ports and one
// synchronous write port. x0 always reads as zero.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module register_file (
    input  logic                clock,
    input  logic                reset,
    input  logic                wr_en,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// Top level of the multicycle RV32I core.
// Connects the control FSM to the datapath and exposes the memory
// request/acknowledge ports and the ecall / illegal_instruction pulses.

`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  logic                clock,
    input  logic                reset,
    output logic                mem_rd_en,
    output logic                mem_wr_en,
    output logic [3:0]          mem_byte_en,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    input  logic                mem_ack,
    output logic                ecall,
    output logic                illegal_instruction
);

    rv_pkg::instr_word_t instr;
    rv_pkg::wb_sel_t     wb_sel;
    logic [3:0]          alu_op;
    logic                alua_src;
    logic                alub_src;
    logic                sub;
    logic                arithmetic;
    logic                alupc_src;
    logic                pc_src;
    logic                pc_en;
    logic                wr_reg_en;
    logic                ir_en;
    logic                mem_addr_src;
    logic                zero;
    logic                negative;
    logic                carry_out;
    logic                overflow;

    control_unit control_unit_i (
        .clock, .reset, .mem_ack, .instr,
        .zero, .negative, .carry_out, .overflow,
        .mem_rd_en, .mem_wr_en, .mem_byte_en,
        .alua_src, .alub_src, .alu_op, .sub, .arithmetic,
        .alupc_src, .pc_src, .pc_en, .wb_sel, .wr_reg_en,
        .ir_en, .mem_addr_src, .ecall, .illegal_instruction
    );

    datapath datapath_i (
        .clock, .reset,
        .alua_src, .alub_src, .alu_op, .sub, .arithmetic,
        .alupc_src, .pc_src, .pc_en, .wb_sel, .wr_reg_en,
        .ir_en, .mem_addr_src,
        .instr, .mem_addr, .mem_wdata,
        .zero, .negative, .carry_out, .overflow,
        .mem_rdata
    );

endmodule

`default_nettype wire

//--- verilog/rv_defines.svh
// Shared widths, reset PC and RV32I major opcodes for the multicycle core.
// Included by every RTL file that sizes a port or decodes an opcode.

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN      32
`define RV_REG_COUNT 32
`define RV_RESET_PC  32'h0000_0000

// Major opcodes, instr[6:0]
`define RV_OP_REG    7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_FENCE  7'b0001111
`define RV_OP_SYSTEM 7'b1110011

`endif

//--- verilog/rv_pkg.sv
// Types shared by the controller, the datapath and the testbench.
// Referenced by scoped names only.

`default_nettype none

package rv_pkg;

    typedef enum logic [4:0] {
        IDLE, FETCH, DECODE,
        REG_REG, REG_IMM, LUI, AUIPC,
        JAL, JALR, BRANCH,
        LOAD, STORE,
        ECALL, FENCE, ILLEGAL
    } ctrl_state_t;

    typedef enum logic [1:0] {
        ALU, MEM, PC_PLUS4
    } wb_sel_t;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // S/B-type layout, immediate split around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r_view;
        s_fields_t s_view;
    } instr_word_t;

endpackage

`default_nettype wire
